// ==== src.f ====
+incdir+include
hw/div_op_pkg.sv
hw/div_ctl_pkg.sv
hw/div_operand_capture.sv
hw/div_smallnum.sv
hw/div_iter_core.sv
hw/div_result_fix.sv
hw/div_top.sv
bench/div_assert.sv
bench/div_tb.sv

// ==== Makefile ====
# Verilator simulation of the divider testbench

VERILATOR ?= verilator
TOP       ?= div_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
EXTRA     ?=

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "TEST PASSED" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/div_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "div_cfg.svh"

module div_tb
  import div_op_pkg::*;
();

  localparam int CLK_PERIOD = 4;
  localparam int NUM_OPS    = 400;
  localparam int DIRECTED   = 16;  // Headroom for the directed cases
  localparam int OP_CYCLES  = 40;  // Longest operation plus idle gap
  localparam int TIMEOUT_NS = (NUM_OPS + DIRECTED) * OP_CYCLES * CLK_PERIOD;

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic                 start;
  div_op_e              op;
  logic [`DIV_XLEN-1:0] dividend;
  logic [`DIV_XLEN-1:0] divisor;
  logic                 flush;
  logic                 fast_disable;
  logic                 busy;
  logic                 done;
  logic                 done_early;
  logic [`DIV_XLEN-1:0] result;

  integer               seed;
  div_op_e              cur_op;
  logic [`DIV_XLEN-1:0] cur_a;
  logic [`DIV_XLEN-1:0] cur_b;
  int                   n_checked;
  int                   n_fast;
  int                   n_flushed;

  always #(CLK_PERIOD / 2) clk = ~clk;

  div_top dut_i (
    .clk, .rst_n, .start, .op, .dividend, .divisor, .flush, .fast_disable,
    .busy, .done, .done_early, .result
  );

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("  op %s dividend 0x%h divisor 0x%h at %0t", cur_op.name(), cur_a, cur_b, $time);
    $display("TEST FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [`DIV_XLEN-1:0] got,
                             input logic [`DIV_XLEN-1:0] exp);
    assert (got === exp) else begin
      stop_on_error($sformatf("CHECK FAILED: %s expected 0x%h got 0x%h", name, exp, got));
    end
  endtask

  // RISC-V M extension results, quotient rounds toward zero
  function automatic logic [`DIV_XLEN-1:0] model_result(input div_op_e o,
      input logic [`DIV_XLEN-1:0] a, input logic [`DIV_XLEN-1:0] b);
    logic signed [`DIV_XLEN-1:0] sa;
    logic signed [`DIV_XLEN-1:0] sb;
    sa = a;
    sb = b;
    if (b == '0) begin
      return (o == OP_DIV || o == OP_DIVU) ? '1 : a;
    end
    if ((o == OP_DIV || o == OP_REM) && a == 32'h8000_0000 && b == '1) begin
      return (o == OP_DIV) ? a : '0;  // Signed overflow
    end
    case (o)
      OP_DIV:  return sa / sb;
      OP_DIVU: return a / b;
      OP_REM:  return sa % sb;
      default: return a % b;
    endcase
  endfunction

  function automatic logic fast_expected(input div_op_e o, input logic [`DIV_XLEN-1:0] a,
                                         input logic [`DIV_XLEN-1:0] b, input logic fd);
    if (fd || o == OP_REM || o == OP_REMU || b == '0) begin
      return 1'b0;
    end
    return (a < 16 && b < 16) || (a == '0);
  endfunction

  // Cycles from the start cycle to done
  function automatic int op_latency(input div_op_e o, input logic [`DIV_XLEN-1:0] a,
                                    input logic [`DIV_XLEN-1:0] b, input logic fd);
    if (fast_expected(o, a, b, fd)) begin
      return 3;
    end
    return (o == OP_REM || o == OP_REMU) ? 35 : 34;
  endfunction

  task automatic pick_operands(output div_op_e o, output logic [`DIV_XLEN-1:0] a,
                               output logic [`DIV_XLEN-1:0] b);
    logic [31:0] r;
    int          kind;
    r    = $random(seed);
    o    = div_op_e'(r[1:0]);
    kind = int'(r[6:4]);
    a    = $random(seed);
    b    = $random(seed);
    case (kind)
      3, 4: begin
        a = a & 32'hf;
        b = b & 32'hf;
      end
      5: b = '0;
      6: begin
        a = 32'h8000_0000;
        b = '1;
      end
      7: a = '0;
      default: ;  // Full range
    endcase
  endtask

  // flush_at below zero means no flush, extra_at of zero means no extra start
  task automatic run_op(input div_op_e o, input logic [`DIV_XLEN-1:0] a,
                        input logic [`DIV_XLEN-1:0] b, input logic fd,
                        input int flush_at, input int extra_at);
    logic [`DIV_XLEN-1:0] exp_res;
    logic                 exp_early;
    int                   lat;
    exp_res   = model_result(o, a, b);
    exp_early = fast_expected(o, a, b, fd);
    lat       = op_latency(o, a, b, fd);
    cur_op    = o;
    cur_a     = a;
    cur_b     = b;
    op           = o;
    dividend     = a;
    divisor      = b;
    fast_disable = fd;  // Held for the whole operation
    start        = 1'b1;
    flush        = (flush_at == 0);
    for (int cyc = 1; cyc <= lat + 2; cyc++) begin
      @(negedge clk);
      start = 1'b0;
      flush = 1'b0;
      if (flush_at >= 0) begin
        assert (!done) else stop_on_error("done raised for a flushed operation");
        if (cyc > flush_at) begin
          assert (!busy) else stop_on_error("busy still high after the flush");
        end
        if (cyc == flush_at) begin
          flush = 1'b1;
        end
      end else if (cyc == lat) begin
        assert (done) else stop_on_error($sformatf("no done %0d cycles after start", lat));
        check_value("done_early", {31'b0, done_early}, {31'b0, exp_early});
        check_value("result", result, exp_res);
        check_value("busy", {31'b0, busy}, 32'h0);
        n_checked++;
        if (exp_early) begin
          n_fast++;
        end
        return;
      end else begin
        assert (!done) else stop_on_error("done arrived before the expected cycle");
        check_value("busy", {31'b0, busy}, 32'h1);  // Up to the finish cycle
        if (cyc == extra_at) begin
          start    = 1'b1;  // Must be dropped by the DUT
          op       = div_op_e'(2'($random(seed)));
          dividend = $random(seed);
          divisor  = $random(seed);
        end
      end
    end
    n_flushed++;
  endtask

  initial begin
    #(TIMEOUT_NS);
    stop_on_error("watchdog expired before all operations finished");
  end

  initial begin
    div_op_e              o;
    logic [`DIV_XLEN-1:0] a;
    logic [`DIV_XLEN-1:0] b;
    logic [31:0]          r;
    logic                 fd;
    int                   lat;
    int                   flush_at;
    int                   extra_at;
    seed         = 32'h7dd3;
    cur_op       = OP_DIV;
    cur_a        = '0;
    cur_b        = '0;
    n_checked    = 0;
    n_fast       = 0;
    n_flushed    = 0;
    rst_n        = 1'b0;
    start        = 1'b0;
    op           = OP_DIV;
    dividend     = '0;
    divisor      = '0;
    flush        = 1'b0;
    fast_disable = 1'b0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    check_value("busy", {31'b0, busy}, 32'h0);
    check_value("done", {31'b0, done}, 32'h0);
    check_value("result", result, 32'h0);

    run_op(OP_DIVU, 32'd9, 32'd2, 1'b0, -1, 0);
    run_op(OP_DIVU, 32'd9, 32'd2, 1'b1, -1, 0);  // Same operands, fast path off
    run_op(OP_DIV, 32'd0, 32'hffff_fff9, 1'b0, -1, 0);
    run_op(OP_DIV, 32'h8000_0000, 32'hffff_ffff, 1'b0, -1, 0);
    run_op(OP_REM, 32'h8000_0000, 32'hffff_ffff, 1'b0, -1, 0);
    run_op(OP_DIVU, 32'd1234, 32'd0, 1'b0, -1, 0);
    run_op(OP_REMU, 32'd1234, 32'd0, 1'b0, -1, 0);
    run_op(OP_DIV, 32'hffff_ff85, 32'd7, 1'b0, -1, 0);
    run_op(OP_REM, 32'hffff_ff85, 32'd7, 1'b0, 10, 0);
    run_op(OP_REM, 32'hffff_ff85, 32'hffff_fff9, 1'b0, -1, 5);
    run_op(OP_DIVU, 32'd7, 32'd3, 1'b0, 0, 0);  // Flush in the start cycle
    run_op(OP_DIVU, 32'd7, 32'd3, 1'b0, -1, 0);

    for (int i = 0; i < NUM_OPS; i++) begin
      pick_operands(o, a, b);
      r        = $random(seed);
      fd       = r[0];
      lat      = op_latency(o, a, b, fd);
      flush_at = -1;
      extra_at = 0;
      if ($unsigned($random(seed)) % 10 == 0) begin
        flush_at = $unsigned($random(seed)) % (lat - 1);
      end else if ($unsigned($random(seed)) % 16 == 0) begin
        extra_at = 1 + $unsigned($random(seed)) % (lat - 1);
      end
      run_op(o, a, b, fd, flush_at, extra_at);
      repeat ($unsigned($random(seed)) % 3) @(negedge clk);
    end

    $display("%0d results checked, %0d fast, %0d flushed", n_checked, n_fast, n_flushed);
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/div_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_assert (
  input logic clk,
  input logic rst_n,
  input logic flush,
  input logic busy,
  input logic finish
);

  finish_busy_a: assert property (@(posedge clk) disable iff (!rst_n) finish |-> busy)
    else $error("finish high while busy is low");

  // FINISH always falls back to IDLE
  finish_pulse_a: assert property (@(posedge clk) disable iff (!rst_n) finish |=> !finish)
    else $error("finish held for more than one cycle");

  flush_busy_a: assert property (@(posedge clk) disable iff (!rst_n) flush |=> !busy)
    else $error("busy still high in the cycle after a flush");

endmodule

bind div_iter_core div_assert assert_i (
  .clk    (clk),
  .rst_n  (rst_n),
  .flush  (flush),
  .busy   (busy),
  .finish (finish)
);

`default_nettype wire

// ==== hw/div_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "div_cfg.svh"

module div_top
  import div_op_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  input  div_op_e              op,
  input  logic [`DIV_XLEN-1:0] dividend,
  input  logic [`DIV_XLEN-1:0] divisor,
  input  logic                 flush,
  input  logic                 fast_disable,
  output logic                 busy,
  output logic                 done,
  output logic                 done_early,
  output logic [`DIV_XLEN-1:0] result
);

  logic                    load;
  logic [`DIV_XLEN-1:0]    q_init;
  logic [`DIV_XLEN:0]      m_init;
  logic                    dividend_neg;
  logic                    divisor_neg;
  logic                    signed_eff;
  logic                    rem_op;
  logic                    small_hit;
  logic [`DIV_SMALL_W-1:0] small_quot;
  logic                    finish;
  logic                    small_sel;
  logic [`DIV_XLEN-1:0]    quot;
  logic [`DIV_XLEN-1:0]    rem_raw;

  div_operand_capture capture_i (
    .clk, .rst_n, .start, .op, .dividend, .divisor, .busy,
    .load, .q_init, .m_init, .dividend_neg, .divisor_neg, .signed_eff, .rem_op
  );

  // Fast path decision during the load cycle
  div_smallnum small_i (
    .clk, .rst_n, .load, .q_init, .m_init, .rem_op, .fast_disable,
    .small_hit, .small_quot
  );

  div_iter_core core_i (
    .clk,
    .rst_n,
    .load,
    .q_init,
    .m_init,
    .divisor_neg,
    .signed_eff,
    .rem_op,
    .small_hit,
    .flush,
    .busy,
    .finish,
    .small_sel,
    .quot,
    .rem_raw
  );

  div_result_fix fix_i (
    .clk, .rst_n, .finish, .small_sel, .quot, .rem_raw, .small_quot,
    .dividend_neg, .divisor_neg, .signed_eff, .rem_op,
    .done, .done_early, .result
  );

endmodule

`default_nettype wire

// ==== hw/div_result_fix.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "div_cfg.svh"

module div_result_fix (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    finish,
  input  logic                    small_sel,
  input  logic [`DIV_XLEN-1:0]    quot,
  input  logic [`DIV_XLEN-1:0]    rem_raw,
  input  logic [`DIV_SMALL_W-1:0] small_quot,
  input  logic                    dividend_neg,
  input  logic                    divisor_neg,
  input  logic                    signed_eff,
  input  logic                    rem_op,
  output logic                    done,
  output logic                    done_early,
  output logic [`DIV_XLEN-1:0]    result
);

  logic [`DIV_XLEN-1:0] quot_fix;
  logic [`DIV_XLEN-1:0] rem_fix;
  logic [`DIV_XLEN-1:0] result_sel;

  assign quot_fix = (signed_eff & (dividend_neg ^ divisor_neg)) ? -quot : quot;
  assign rem_fix  = (signed_eff & dividend_neg) ? -rem_raw : rem_raw;  // Follows dividend

  always_comb begin
    if (small_sel) begin
      result_sel = {{(`DIV_XLEN - `DIV_SMALL_W){1'b0}}, small_quot};
    end else if (rem_op) begin
      result_sel = rem_fix;
    end else begin
      result_sel = quot_fix;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done       <= 1'b0;
      done_early <= 1'b0;
      result     <= '0;
    end else begin
      done       <= finish;
      done_early <= finish & small_sel;
      if (finish) begin
        result <= result_sel;  // Held until the next done
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/div_iter_core.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "div_cfg.svh"

module div_iter_core
  import div_ctl_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 load,
  input  logic [`DIV_XLEN-1:0] q_init,
  input  logic [`DIV_XLEN:0]   m_init,
  input  logic                 divisor_neg,
  input  logic                 signed_eff,
  input  logic                 rem_op,
  input  logic                 small_hit,
  input  logic                 flush,
  output logic                 busy,
  output logic                 finish,
  output logic                 small_sel,
  output logic [`DIV_XLEN-1:0] quot,
  output logic [`DIV_XLEN-1:0] rem_raw
);

  div_state_e            state;
  div_state_e            state_nxt;
  logic [`DIV_CNT_W-1:0] cnt;
  logic                  flush_q;
  logic                  load_ok;
  logic                  m_neg;
  logic                  add;
  logic [`DIV_XLEN-1:0]  dividend_abs;
  logic [`DIV_XLEN-1:0]  q_q;
  logic [`DIV_XLEN-1:0]  q_cur;
  logic [`DIV_XLEN:0]    a_q;
  logic [`DIV_XLEN:0]    a_cur;
  logic [`DIV_XLEN:0]    a_shift;
  logic [`DIV_XLEN:0]    a_step;
  logic [`DIV_XLEN:0]    a_corr;

  assign load_ok = load & ~flush_q;  // Flush in the start cycle kills the load
  assign m_neg   = divisor_neg & signed_eff;

  assign dividend_abs = (signed_eff & q_init[`DIV_XLEN-1]) ? -q_init : q_init;

  // First step runs straight off the captured operands
  assign a_cur = load ? '0 : a_q;
  assign q_cur = load ? dividend_abs : q_q;

  // Add on negative partial remainder, swapped when the divisor is negative
  assign add     = a_cur[`DIV_XLEN] ^ m_neg;
  assign a_shift = {a_cur[`DIV_XLEN-1:0], q_cur[`DIV_XLEN-1]};
  assign a_step  = add ? a_shift + m_init : a_shift - m_init;
  assign a_corr  = m_neg ? a_q - m_init : a_q + m_init;  // Adds back |divisor|

  always_comb begin
    state_nxt = state;
    case (state)
      DIV_IDLE: begin
        if (load_ok) begin
          state_nxt = small_hit ? DIV_FINISH : DIV_RUN;
        end
      end
      DIV_RUN: begin
        if (cnt == `DIV_CNT_W'(`DIV_STEPS - 1)) begin
          state_nxt = rem_op ? DIV_CORRECT : DIV_FINISH;
        end
      end
      DIV_CORRECT: state_nxt = DIV_FINISH;
      default:     state_nxt = DIV_IDLE;
    endcase
    if (flush) begin
      state_nxt = DIV_IDLE;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= DIV_IDLE;
      cnt       <= '0;
      flush_q   <= 1'b0;
      small_sel <= 1'b0;
    end else begin
      state   <= state_nxt;
      flush_q <= flush;
      if (load_ok) begin
        cnt       <= `DIV_CNT_W'(1);  // Load cycle does step one
        small_sel <= small_hit;
      end else if (state == DIV_RUN) begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load_ok || (state == DIV_RUN)) begin
      a_q <= a_step;
      q_q <= {q_cur[`DIV_XLEN-2:0], ~a_step[`DIV_XLEN]};
    end else if ((state == DIV_CORRECT) && a_q[`DIV_XLEN]) begin
      a_q <= a_corr;
    end
  end

  assign busy    = load_ok | (state != DIV_IDLE);
  assign finish  = (state == DIV_FINISH);
  assign quot    = q_q;
  assign rem_raw = a_q[`DIV_XLEN-1:0];

endmodule

`default_nettype wire

// ==== hw/div_smallnum.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "div_cfg.svh"

module div_smallnum (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    load,
  input  logic [`DIV_XLEN-1:0]    q_init,
  input  logic [`DIV_XLEN:0]      m_init,
  input  logic                    rem_op,
  input  logic                    fast_disable,
  output logic                    small_hit,
  output logic [`DIV_SMALL_W-1:0] small_quot
);

  logic                    fits;
  logic [`DIV_SMALL_W-1:0] lut_quot;

  // Small restoring divide, flattens into a 256 entry table
  function automatic logic [`DIV_SMALL_W-1:0] small_div(
    input logic [`DIV_SMALL_W-1:0] n,
    input logic [`DIV_SMALL_W-1:0] d
  );
    logic [`DIV_SMALL_W:0]   r;
    logic [`DIV_SMALL_W-1:0] q;
    r = '0;
    q = '0;
    for (int i = `DIV_SMALL_W - 1; i >= 0; i--) begin
      r = {r[`DIV_SMALL_W-1:0], n[i]};
      if (r >= {1'b0, d}) begin
        r    = r - {1'b0, d};
        q[i] = 1'b1;
      end
    end
    return q;
  endfunction

  // Negative signed operands fail this check
  assign fits = (q_init[`DIV_XLEN-1:`DIV_SMALL_W] == '0) &&
                (m_init[`DIV_XLEN:`DIV_SMALL_W] == '0);

  assign small_hit = load & ~rem_op & ~fast_disable & (m_init != '0) &
                     (fits | (q_init == '0));

  // Low divisor nibble is zero only for a zero dividend here
  assign lut_quot = (m_init[`DIV_SMALL_W-1:0] == '0) ? '0 :
                    small_div(q_init[`DIV_SMALL_W-1:0], m_init[`DIV_SMALL_W-1:0]);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      small_quot <= '0;
    end else if (small_hit) begin
      small_quot <= lut_quot;
    end
  end

endmodule

`default_nettype wire

// ==== hw/div_operand_capture.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "div_cfg.svh"

module div_operand_capture
  import div_op_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  input  div_op_e              op,
  input  logic [`DIV_XLEN-1:0] dividend,
  input  logic [`DIV_XLEN-1:0] divisor,
  input  logic                 busy,
  output logic                 load,
  output logic [`DIV_XLEN-1:0] q_init,
  output logic [`DIV_XLEN:0]   m_init,
  output logic                 dividend_neg,
  output logic                 divisor_neg,
  output logic                 signed_eff,
  output logic                 rem_op
);

  logic accept;
  logic op_signed;
  logic op_rem;

  assign accept    = start & ~busy;  // Starts while busy are dropped
  assign op_signed = (op == OP_DIV) || (op == OP_REM);
  assign op_rem    = (op == OP_REM) || (op == OP_REMU);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      load <= 1'b0;
    end else begin
      load <= accept;
    end
  end

  // Operands and flags stay put for the whole operation
  always_ff @(posedge clk) begin
    if (accept) begin
      q_init       <= dividend;
      m_init       <= {op_signed & divisor[`DIV_XLEN-1], divisor};
      dividend_neg <= dividend[`DIV_XLEN-1];
      divisor_neg  <= divisor[`DIV_XLEN-1];
      // Divide by zero runs unsigned, gives all ones and the dividend back
      signed_eff   <= op_signed & (divisor != '0);
      rem_op       <= op_rem;
    end
  end

endmodule

`default_nettype wire

// ==== hw/div_ctl_pkg.sv ====
`default_nettype none

package div_ctl_pkg;

  typedef enum logic [1:0] {
    DIV_IDLE    = 2'b00,
    DIV_RUN     = 2'b01,  // One quotient bit per cycle
    DIV_CORRECT = 2'b10,  // Remainder fix-up
    DIV_FINISH  = 2'b11
  } div_state_e;

endpackage

`default_nettype wire

// ==== hw/div_op_pkg.sv ====
`default_nettype none

package div_op_pkg;

  // Bit 1 picks the remainder, bit 0 marks an unsigned operation
  typedef enum logic [1:0] {
    OP_DIV  = 2'b00,  // Signed quotient
    OP_DIVU = 2'b01,  // Unsigned quotient
    OP_REM  = 2'b10,  // Signed remainder
    OP_REMU = 2'b11   // Unsigned remainder
  } div_op_e;

endpackage

`default_nettype wire

// ==== include/div_cfg.svh ====
`ifndef DIV_CFG_SVH
`define DIV_CFG_SVH

// Operand and result width
`define DIV_XLEN 32

`define DIV_CNT_W 6    // Wide enough to count past the last step

// One quotient bit per step, remainder correction follows as an extra step
`define DIV_STEPS 32

`define DIV_SMALL_W 4  // Operand width handled by the fast path

`endif
